// File: src/sdc_pkg.sv
`default_nettype none

package sdc_pkg;

    //////////////////////////////////////////////////
    // widths and base types

    localparam int ADDR_W = 16;                 // z80 address
    localparam int DATA_W = 8;                  // z80 data
    localparam int SECT_W = 9;                  // 512 byte sector
    localparam int LBA_W  = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [SECT_W-1:0] sector_addr_t;
    typedef logic [LBA_W-1:0]  lba_t;
    typedef logic [1:0]        card_type_t;     // 0 unknown, 1 sdv1, 2 sdv2, 3 sdhcv2
    typedef logic [2:0]        msel_t;          // active low mux select

    //////////////////////////////////////////////////
    // board multiplexer phases

    localparam msel_t MSEL_ADDR_LO = 3'b110;    // a0-a7
    localparam msel_t MSEL_ADDR_HI = 3'b101;    // a8-a15
    localparam msel_t MSEL_CTRL    = 3'b011;    // merq, iorq, m1
    localparam msel_t MSEL_NONE    = 3'b111;

    // bit positions inside the control byte
    localparam int CTRL_MERQ_BIT = 0;
    localparam int CTRL_IORQ_BIT = 1;
    localparam int CTRL_M1_BIT   = 7;

    //////////////////////////////////////////////////
    // register map, offsets from the window base

    localparam int OFS_SDATA  = 'h000;          // sector window, 512 bytes
    localparam int OFS_ENABLE = 'h200;
    localparam int OFS_CMD    = 'h201;
    localparam int OFS_STATUS = 'h202;
    localparam int OFS_SADDR  = 'h203;          // 4 bytes, little endian
    localparam int OFS_CTYPE  = 'h20E;
    localparam int OFS_END    = 'h2FF;

    localparam int CMD_RSTART_BIT = 0;
    localparam int CMD_WSTART_BIT = 1;
    localparam int CMD_INIT_BIT   = 7;

    localparam addr_t SDC_BASE_DEFAULT = 16'h7C00;

endpackage

`default_nettype wire

// File: src/bus_sampler.sv
`default_nettype none
`timescale 1ns/100ps

module bus_sampler (
    input  wire                    clk108_w,
    input  wire                    ram_enabled_w,
    input  wire sdc_pkg::byte_t    mp,
    input  wire sdc_pkg::byte_t    cd_in,
    input  wire                    rd_n,
    input  wire                    wr_n,
    input  wire                    sltsl_n,
    output sdc_pkg::msel_t         msel_n,
    output logic                   snap_valid,
    output sdc_pkg::addr_t         addr,
    output sdc_pkg::byte_t         data,
    output logic                   merq_n,
    output logic                   iorq_n,
    output logic                   m1_n,
    output logic                   rd_n_s,
    output logic                   wr_n_s,
    output logic                   sltsl_n_s
);

    import sdc_pkg::*;

    logic [2:0] phase;              // frame cycle
    byte_t      addr_lo_q;
    byte_t      addr_hi_q;
    logic       take_lo;
    logic       take_hi;
    logic       take_ctrl;

    // second cycle of each mux window
    assign take_lo   = (phase == 3'd2);
    assign take_hi   = (phase == 3'd4);
    assign take_ctrl = (phase == 3'd6);

    //////////////////////////////////////////////////
    // phase sequencer

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase      <= 3'd0;
            msel_n     <= MSEL_NONE;
            snap_valid <= 1'b0;
        end else begin
            phase      <= phase + 3'd1;   // wraps every 8
            snap_valid <= take_ctrl;      // high in frame cycle 7
            case (phase)
                3'd0:    msel_n <= MSEL_ADDR_LO;
                3'd2:    msel_n <= MSEL_ADDR_HI;
                3'd4:    msel_n <= MSEL_CTRL;
                3'd6:    msel_n <= MSEL_NONE;
                default: msel_n <= msel_n;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // snapshot

    // strobes idle high until the first frame lands
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n    <= 1'b1;
            iorq_n    <= 1'b1;
            m1_n      <= 1'b1;
            rd_n_s    <= 1'b1;
            wr_n_s    <= 1'b1;
            sltsl_n_s <= 1'b1;
        end else if (take_ctrl) begin
            merq_n    <= mp[CTRL_MERQ_BIT];
            iorq_n    <= mp[CTRL_IORQ_BIT];
            m1_n      <= mp[CTRL_M1_BIT];
            rd_n_s    <= rd_n;
            wr_n_s    <= wr_n;
            sltsl_n_s <= sltsl_n;
        end
    end

    always_ff @(posedge clk108_w) begin
        if (take_lo)
            addr_lo_q <= mp;
        if (take_hi)
            addr_hi_q <= mp;
        // both halves move together so the consumer never sees a torn address
        if (take_ctrl) begin
            addr <= {addr_hi_q, addr_lo_q};
            data <= cd_in;
        end
    end

endmodule

`default_nettype wire

// File: src/sector_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module sector_buffer (
    input  wire                         clk108_w,
    // cpu side
    input  wire sdc_pkg::sector_addr_t  cpu_addr,
    input  wire                         cpu_we,
    input  wire sdc_pkg::byte_t         cpu_wdata,
    output sdc_pkg::byte_t              cpu_rdata,
    // card engine side
    input  wire sdc_pkg::sector_addr_t  card_addr,
    input  wire                         card_we,
    input  wire sdc_pkg::byte_t         card_wdata,
    output sdc_pkg::byte_t              card_rdata
);

    import sdc_pkg::*;

    localparam int DEPTH = 1 << SECT_W;

    byte_t mem [DEPTH];

    // one sector, both ports read registered
    always_ff @(posedge clk108_w) begin
        if (cpu_we)
            mem[cpu_addr] <= cpu_wdata;
        if (card_we)
            mem[card_addr] <= card_wdata;   // card wins on a same-address clash

        // old data on read during write
        cpu_rdata  <= mem[cpu_addr];
        card_rdata <= mem[card_addr];
    end

endmodule

`default_nettype wire

// File: src/sdc_registers.sv
`default_nettype none
`timescale 1ns/100ps

module sdc_registers #(
    parameter sdc_pkg::addr_t SDC_BASE = sdc_pkg::SDC_BASE_DEFAULT
) (
    input  wire                         clk108_w,
    input  wire                         ram_enabled_w,
    // bus snapshot
    input  wire                         snap_valid,
    input  wire sdc_pkg::addr_t         addr,
    input  wire sdc_pkg::byte_t         data,
    input  wire                         merq_n,
    input  wire                         iorq_n,
    input  wire                         m1_n,
    input  wire                         rd_n_s,
    input  wire                         wr_n_s,
    input  wire                         sltsl_n_s,
    // sector buffer, cpu port
    output sdc_pkg::sector_addr_t       buf_addr,
    output logic                        buf_we,
    output sdc_pkg::byte_t              buf_wdata,
    input  wire sdc_pkg::byte_t         buf_rdata,
    // card engine
    input  wire                         card_busy,
    input  wire                         card_done,
    input  wire                         card_crc_error,
    input  wire                         card_timeout_error,
    input  wire sdc_pkg::card_type_t    card_type,
    input  wire                         card_outen,
    output logic                        card_buf_we,
    output logic                        card_rstart,
    output logic                        card_wstart,
    output logic                        card_init,
    output sdc_pkg::lba_t               card_sector,
    // data bus
    output sdc_pkg::byte_t              cd_out,
    output logic                        datadir
);

    import sdc_pkg::*;

    logic [9:0] ofs;                // offset inside the 1k window
    logic       win_hit;
    logic       mem_cycle;
    logic       in_sdata;
    logic       in_regs;
    logic       is_enable;
    logic       resp;
    logic       cpu_rd;
    logic       cpu_wr;
    logic       sd_en;
    logic       rd_buf_q;           // sector read waits one cycle for the ram
    byte_t      reg_rdata;

    //////////////////////////////////////////////////
    // address decode

    assign ofs       = addr[9:0];
    assign win_hit   = (addr[15:10] == SDC_BASE[15:10]);
    assign mem_cycle = !merq_n && iorq_n && m1_n && !sltsl_n_s;
    assign in_sdata  = (ofs < 10'(OFS_ENABLE));
    assign in_regs   = !in_sdata && (ofs <= 10'(OFS_END));
    assign is_enable = (ofs == 10'(OFS_ENABLE));

    // enable register answers even while the window is off
    assign resp   = mem_cycle && win_hit && (is_enable || (sd_en && (in_sdata || in_regs)));
    assign cpu_rd = snap_valid && resp && !rd_n_s;
    assign cpu_wr = snap_valid && resp && !wr_n_s;

    // cpu port of the sector buffer
    assign buf_addr  = sector_addr_t'(ofs - 10'(OFS_SDATA));
    assign buf_we    = cpu_wr && in_sdata;
    assign buf_wdata = data;

    assign card_buf_we = card_outen && card_rstart;   // card fills the buffer on reads only

    //////////////////////////////////////////////////
    // readback mux

    always_comb begin
        case (ofs)
            10'(OFS_ENABLE): reg_rdata = {7'b0, sd_en};
            10'(OFS_STATUS): reg_rdata = {card_busy, 5'b0, card_timeout_error, card_crc_error};
            10'(OFS_CTYPE):  reg_rdata = {6'b0, card_type};
            default:         reg_rdata = 8'hFF;     // csd/cid bytes and write-only regs
        endcase
    end

    //////////////////////////////////////////////////
    // control registers

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en       <= 1'b0;
            card_rstart <= 1'b0;
            card_wstart <= 1'b0;
            card_init   <= 1'b0;
            rd_buf_q    <= 1'b0;
            datadir     <= 1'b1;
        end else begin
            rd_buf_q <= cpu_rd && in_sdata;

            if (card_done) begin
                card_rstart <= 1'b0;
                card_wstart <= 1'b0;
            end

            // drive the bus from the frame after a hit until the first miss
            if (snap_valid)
                datadir <= !(resp && !rd_n_s);

            if (cpu_wr) begin
                case (ofs)
                    10'(OFS_ENABLE): sd_en <= data[0];
                    10'(OFS_CMD): begin
                        card_rstart <= card_rstart | data[CMD_RSTART_BIT];
                        card_wstart <= card_wstart | data[CMD_WSTART_BIT];
                        card_init   <= card_init   | data[CMD_INIT_BIT];  // sticky
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // sector number and read data

    always_ff @(posedge clk108_w) begin
        if (cpu_wr) begin
            case (ofs)
                10'(OFS_SADDR + 0): card_sector[7:0]   <= data;
                10'(OFS_SADDR + 1): card_sector[15:8]  <= data;
                10'(OFS_SADDR + 2): card_sector[23:16] <= data;
                10'(OFS_SADDR + 3): card_sector[31:24] <= data;
                default: ;
            endcase
        end

        if (cpu_rd && !in_sdata)
            cd_out <= reg_rdata;
        else if (rd_buf_q)
            cd_out <= buf_rdata;    // ram output for the snapshot address
    end

endmodule

`default_nettype wire

// File: src/sdc_top.sv
`default_nettype none
`timescale 1ns/100ps

module sdc_top #(
    parameter sdc_pkg::addr_t SDC_BASE = sdc_pkg::SDC_BASE_DEFAULT
) (
    input  wire                         clk108_w,
    input  wire                         ram_enabled_w,
    // msx bus through the board mux
    input  wire sdc_pkg::byte_t         mp,
    input  wire sdc_pkg::byte_t         cd_in,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire                         sltsl_n,
    output sdc_pkg::msel_t              msel_n,
    output sdc_pkg::byte_t              cd_out,
    output logic                        datadir,
    // card engine
    input  wire                         card_busy,
    input  wire                         card_done,
    input  wire                         card_crc_error,
    input  wire                         card_timeout_error,
    input  wire sdc_pkg::card_type_t    card_type,
    input  wire                         card_outen,
    input  wire sdc_pkg::sector_addr_t  card_outaddr,
    input  wire sdc_pkg::byte_t         card_outbyte,
    output logic                        card_rstart,
    output logic                        card_wstart,
    output logic                        card_init,
    output sdc_pkg::lba_t               card_sector,
    output sdc_pkg::byte_t              card_inbyte
);

    import sdc_pkg::*;

    // snapshot
    logic         snap_valid;
    addr_t        addr;
    byte_t        data;
    logic         merq_n;
    logic         iorq_n;
    logic         m1_n;
    logic         rd_n_s;
    logic         wr_n_s;
    logic         sltsl_n_s;

    // cpu port of the buffer
    sector_addr_t buf_addr;
    logic         buf_we;
    byte_t        buf_wdata;
    byte_t        buf_rdata;
    logic         card_buf_we;

    bus_sampler u_sampler (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cd_in         (cd_in),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .snap_valid    (snap_valid),
        .addr          (addr),
        .data          (data),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .rd_n_s        (rd_n_s),
        .wr_n_s        (wr_n_s),
        .sltsl_n_s     (sltsl_n_s)
    );

    sector_buffer u_buffer (
        .clk108_w   (clk108_w),
        .cpu_addr   (buf_addr),
        .cpu_we     (buf_we),
        .cpu_wdata  (buf_wdata),
        .cpu_rdata  (buf_rdata),
        .card_addr  (card_outaddr),
        .card_we    (card_buf_we),
        .card_wdata (card_outbyte),
        .card_rdata (card_inbyte)
    );

    sdc_registers #(
        .SDC_BASE (SDC_BASE)
    ) u_regs (
        .clk108_w           (clk108_w),
        .ram_enabled_w      (ram_enabled_w),
        .snap_valid         (snap_valid),
        .addr               (addr),
        .data               (data),
        .merq_n             (merq_n),
        .iorq_n             (iorq_n),
        .m1_n               (m1_n),
        .rd_n_s             (rd_n_s),
        .wr_n_s             (wr_n_s),
        .sltsl_n_s          (sltsl_n_s),
        .buf_addr           (buf_addr),
        .buf_we             (buf_we),
        .buf_wdata          (buf_wdata),
        .buf_rdata          (buf_rdata),
        .card_busy          (card_busy),
        .card_done          (card_done),
        .card_crc_error     (card_crc_error),
        .card_timeout_error (card_timeout_error),
        .card_type          (card_type),
        .card_outen         (card_outen),
        .card_buf_we        (card_buf_we),
        .card_rstart        (card_rstart),
        .card_wstart        (card_wstart),
        .card_init          (card_init),
        .card_sector        (card_sector),
        .cd_out             (cd_out),
        .datadir            (datadir)
    );

endmodule

`default_nettype wire

// File: sim/sdc_properties.sv
`default_nettype none
`timescale 1ns/100ps

module sdc_properties (
    input wire                  clk108_w,
    input wire                  ram_enabled_w,
    input wire sdc_pkg::msel_t  msel_n,
    input wire                  snap_valid,
    input wire                  rd_n_s,
    input wire                  datadir
);

    import sdc_pkg::*;

    logic [3:0] gap;            // cycles since the last snapshot
    logic       seen_pulse;
    logic       rd_idle_q;      // rd_n_s of the previous frame

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            gap        <= 4'd0;
            seen_pulse <= 1'b0;
            rd_idle_q  <= 1'b1;
        end else if (snap_valid) begin
            gap        <= 4'd0;
            seen_pulse <= 1'b1;
            rd_idle_q  <= rd_n_s;
        end else begin
            gap <= gap + 4'd1;
        end
    end

    //////////////////////////////////////////////////
    // bus sampling

    msel_legal: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        msel_n == MSEL_ADDR_LO || msel_n == MSEL_ADDR_HI ||
        msel_n == MSEL_CTRL || msel_n == MSEL_NONE)
        else $error("msel_n outside the four mux select codes");

    snap_single: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        snap_valid |=> !snap_valid)
        else $error("snap_valid held for more than one cycle");

    snap_period: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        (snap_valid && seen_pulse) |-> (gap == 4'd7))
        else $error("snap_valid pulses not 8 cycles apart");

    // bus released after two idle frames in a row
    datadir_idle: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        (snap_valid && rd_n_s && rd_idle_q) |=> datadir)
        else $error("datadir low with rd_n high for two frames");

endmodule

bind sdc_top sdc_properties u_props (
    .clk108_w      (clk108_w),
    .ram_enabled_w (ram_enabled_w),
    .msel_n        (msel_n),
    .snap_valid    (snap_valid),
    .rd_n_s        (rd_n_s),
    .datadir       (datadir)
);

`default_nettype wire

// File: sim/tb_sdc.sv
`default_nettype none
`timescale 1ns/100ps

module tb_sdc;

    import sdc_pkg::*;

    localparam logic [31:0] LCG_SEED = 32'he1820d9f;
    localparam byte_t CTRL_MEM  = 8'b1111_1110;     // merq low, iorq and m1 high
    localparam byte_t CTRL_IDLE = 8'hFF;
    // about 570 accesses of at most 6 frames each plus two card transfers
    localparam int ACCESS_MAX = 6 * 8;
    localparam int N_ACCESS   = 600;
    localparam int LIMIT      = 2 * (N_ACCESS * ACCESS_MAX + 2 * (512 + 8)) + 100;

    logic         clk108_w = 1'b0;
    logic         ram_enabled_w;
    byte_t        mp = 8'hFF;
    byte_t        cd_in;
    logic         rd_n;
    logic         wr_n;
    logic         sltsl_n;
    msel_t        msel_n;
    byte_t        cd_out;
    logic         datadir;
    logic         card_busy;
    logic         card_done;
    logic         card_crc_error;
    logic         card_timeout_error;
    card_type_t   card_type;
    logic         card_outen;
    sector_addr_t card_outaddr;
    byte_t        card_outbyte;
    logic         card_rstart;
    logic         card_wstart;
    logic         card_init;
    lba_t         card_sector;
    byte_t        card_inbyte;

    addr_t        bus_addr;             // access held by the cpu model
    byte_t        bus_ctrl;
    logic [31:0]  lcg_state;
    byte_t        card_pattern [512];
    byte_t        shadow [512];         // expected buffer contents
    int           errors = 0;
    int           errors_at_start = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           cycles = 0;

    sdc_top dut (.*);

    always #5 clk108_w = ~clk108_w;

    // board mux model follows the select lines
    always @(negedge clk108_w) begin
        case (msel_n)
            MSEL_ADDR_LO: mp <= bus_addr[7:0];
            MSEL_ADDR_HI: mp <= bus_addr[15:8];
            MSEL_CTRL:    mp <= bus_ctrl;
            default:      mp <= 8'hFF;
        endcase
    end

    always @(posedge clk108_w) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run stopped after %0d cycles, a test never finished", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic byte_t rand_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];
    endfunction

    function automatic addr_t reg_addr(input int ofs);
        return SDC_BASE_DEFAULT + addr_t'(ofs);
    endfunction

    task automatic report_mismatch(input string what, input byte_t got, input byte_t exp);
        $display("FAIL @%0t: %s read %02h, expected %02h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s (at time %0t)", msg, $time);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////
    // cpu bus model

    // returns on the falling edge of frame cycle 7
    task automatic next_frame();
        @(negedge clk108_w);
        while (msel_n != MSEL_CTRL) @(negedge clk108_w);
        while (msel_n != MSEL_NONE) @(negedge clk108_w);
    endtask

    task automatic release_bus();
        bus_addr <= '0;
        bus_ctrl <= CTRL_IDLE;
        sltsl_n  <= 1'b1;
        rd_n     <= 1'b1;
        wr_n     <= 1'b1;
    endtask

    task automatic mem_write(input addr_t a, input byte_t d);
        next_frame();
        bus_addr <= a;
        bus_ctrl <= CTRL_MEM;
        sltsl_n  <= 1'b0;
        wr_n     <= 1'b0;
        cd_in    <= d;
        repeat (3) next_frame();
        release_bus();
        next_frame();
    endtask

    task automatic mem_read(input addr_t a, output byte_t d, output logic driven);
        int n;
        next_frame();
        bus_addr <= a;
        bus_ctrl <= CTRL_MEM;
        sltsl_n  <= 1'b0;
        rd_n     <= 1'b0;
        driven = 1'b0;
        for (n = 0; n < 3 && !driven; n++) begin
            next_frame();
            driven = !datadir;
        end
        if (driven) begin
            next_frame();                   // one more frame on the same address for the ram
            repeat (2) @(negedge clk108_w);
        end
        d = cd_out;
        release_bus();
        next_frame();
    endtask

    task automatic read_expect(input addr_t a, input byte_t exp, input string what);
        byte_t d;
        logic  driven;
        mem_read(a, d, driven);
        if (!driven)
            report_problem($sformatf("%s: datadir never went low", what));
        else if (d !== exp)
            report_mismatch(what, d, exp);
    endtask

    ////////////////////////////////////////////////////
    // card model

    task automatic stream_sector_to_buffer();
        int i;
        for (i = 0; i < 512; i++) begin
            @(negedge clk108_w);
            card_outen   <= 1'b1;
            card_outaddr <= sector_addr_t'(i);
            card_outbyte <= card_pattern[i];
        end
        @(negedge clk108_w);
        card_outen <= 1'b0;
        card_done  <= 1'b1;
        @(negedge clk108_w);
        card_done  <= 1'b0;
    endtask

    task automatic fetch_sector_from_buffer();
        int i;
        @(negedge clk108_w);
        card_outaddr <= '0;
        for (i = 0; i < 512; i++) begin
            @(negedge clk108_w);            // read data one cycle behind the address
            if (card_inbyte !== shadow[i])
                report_mismatch($sformatf("card fetch byte %0d", i), card_inbyte, shadow[i]);
            card_outaddr <= sector_addr_t'(i + 1);
        end
        card_done <= 1'b1;
        @(negedge clk108_w);
        card_done <= 1'b0;
    endtask

    ////////////////////////////////////////////////////
    // directed tests

    task automatic reset_state();
        byte_t d;
        logic  driven;
        if (datadir !== 1'b1)
            report_problem("datadir not high after reset");
        if (card_rstart !== 1'b0 || card_wstart !== 1'b0 || card_init !== 1'b0)
            report_problem("card command bits not low after reset");
        read_expect(reg_addr(OFS_ENABLE), 8'h00, "enable after reset");
        mem_read(reg_addr(OFS_STATUS), d, driven);
        if (driven)
            report_problem("status register answered while the window was disabled");
        finish_test("reset state");
    endtask

    task automatic enable_and_sector();
        lba_t lba;
        int   k;
        lba = {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
        mem_write(reg_addr(OFS_ENABLE), 8'h01);
        for (k = 0; k < 4; k++)
            mem_write(reg_addr(OFS_SADDR + k), lba[8*k +: 8]);   // little endian
        if (card_sector !== lba)
            $display("FAIL @%0t: card_sector %08h, expected %08h", $time, card_sector, lba);
        if (card_sector !== lba)
            errors++;
        read_expect(reg_addr(OFS_ENABLE), 8'h01, "enable after write");
        finish_test("enable and sector address");
    endtask

    task automatic cpu_buffer_access();
        sector_addr_t off;
        byte_t        d;
        int           i;
        for (i = 0; i < 16; i++) begin
            off = sector_addr_t'((i * 31 + 7) % 512);     // scattered distinct offsets
            d = rand_byte();
            shadow[off] = d;
            mem_write(reg_addr(OFS_SDATA + int'(off)), d);
        end
        for (i = 0; i < 16; i++) begin
            off = sector_addr_t'((i * 31 + 7) % 512);
            read_expect(reg_addr(OFS_SDATA + int'(off)), shadow[off],
                        $sformatf("buffer offset %0d", off));
        end
        finish_test("cpu sector buffer access");
    endtask

    task automatic card_to_buffer_read();
        lba_t         lba;
        sector_addr_t off;
        int           i;
        lba = card_sector;
        mem_write(reg_addr(OFS_CMD), 8'h01 << CMD_RSTART_BIT);
        if (card_rstart !== 1'b1) begin
            report_problem("card_rstart did not rise after the read command");
        end else begin
            stream_sector_to_buffer();
            for (i = 0; i < 512; i++)
                shadow[i] = card_pattern[i];
        end
        if (card_sector !== lba)
            report_problem("card_sector changed during the read command");
        @(negedge clk108_w);
        if (card_rstart !== 1'b0)
            report_problem("card_rstart still high after card_done");
        for (i = 0; i < 9; i++) begin
            off = (i == 8) ? 9'd511 : sector_addr_t'((i * 73 + 1) % 512);
            read_expect(reg_addr(OFS_SDATA + int'(off)), card_pattern[off],
                        $sformatf("card data at offset %0d", off));
        end
        finish_test("card to buffer read");
    endtask

    task automatic buffer_to_card_write();
        byte_t d;
        int    i;
        for (i = 0; i < 512; i++) begin
            d = rand_byte();
            shadow[i] = d;
            mem_write(reg_addr(OFS_SDATA + i), d);
        end
        mem_write(reg_addr(OFS_CMD), 8'h01 << CMD_WSTART_BIT);
        if (card_wstart !== 1'b1)
            report_problem("card_wstart did not rise after the write command");
        else
            fetch_sector_from_buffer();
        @(negedge clk108_w);
        if (card_wstart !== 1'b0)
            report_problem("card_wstart still high after card_done");
        mem_write(reg_addr(OFS_CMD), 8'h01 << CMD_INIT_BIT);
        if (card_init !== 1'b1)
            report_problem("card_init not set by the init command");
        mem_write(reg_addr(OFS_CMD), 8'h00);
        if (card_init !== 1'b1)
            report_problem("card_init dropped after a later command write");
        if (card_rstart !== 1'b0 || card_wstart !== 1'b0)
            report_problem("start bits raised by a command without them");
        finish_test("buffer to card write and init");
    endtask

    task automatic status_readback();
        byte_t exp;
        int    k;
        for (k = 0; k < 2; k++) begin
            @(negedge clk108_w);
            card_busy          <= (k == 0);
            card_timeout_error <= (k == 0);
            card_crc_error     <= (k == 1);
            card_type          <= (k == 0) ? 2'd2 : 2'd3;     // sdv2 then sdhcv2
            exp = ((k == 0) ? 8'h80 : 8'h00) | ((k == 0) ? 8'h02 : 8'h00)
                | ((k == 1) ? 8'h01 : 8'h00);
            read_expect(reg_addr(OFS_STATUS), exp, $sformatf("status, set %0d", k));
            read_expect(reg_addr(OFS_CTYPE), (k == 0) ? 8'h02 : 8'h03,
                        $sformatf("card type, set %0d", k));
        end
        read_expect(reg_addr('h210), 8'hFF, "unmapped register");
        finish_test("status and card type readback");
    endtask

    initial begin
        ram_enabled_w      <= 1'b0;
        cd_in              <= '0;
        rd_n               <= 1'b1;
        wr_n               <= 1'b1;
        sltsl_n            <= 1'b1;
        bus_addr           <= '0;
        bus_ctrl           <= CTRL_IDLE;
        card_busy          <= 1'b0;
        card_done          <= 1'b0;
        card_crc_error     <= 1'b0;
        card_timeout_error <= 1'b0;
        card_type          <= 2'd0;
        card_outen         <= 1'b0;
        card_outaddr       <= '0;
        card_outbyte       <= '0;
        lcg_state = LCG_SEED;
        for (int i = 0; i < 512; i++)
            card_pattern[i] = rand_byte();

        repeat (8) @(negedge clk108_w);
        ram_enabled_w <= 1'b1;
        @(negedge clk108_w);

        reset_state();
        enable_and_sector();
        cpu_buffer_access();
        card_to_buffer_read();
        buffer_to_card_write();
        status_readback();

        $display("tests run: %0d, tests with errors: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/sdc_pkg.sv
src/bus_sampler.sv
src/sector_buffer.sv
src/sdc_registers.sv
src/sdc_top.sv
sim/sdc_properties.sv
sim/tb_sdc.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sdc
FLIST     := flist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
